// ==== aud_playback_top.f ====
rtl/aud_pkg.sv
rtl/aud_apb_regs.sv
rtl/aud_sample_ram.sv
rtl/aud_speed_engine.sv
rtl/aud_frame_tx.sv
rtl/aud_playback_top.sv
tests/tb_aud_playback.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the playback testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_aud_playback \
	-f aud_playback_top.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
	exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
	exit 1
fi

// ==== tests/aud_playback_input.txt ====
# columns: mode speed pause stop length, mode 0 fast, 1 hold, 2 linear
# the line after each record holds its samples in decimal
0 1 0 0 6
100 -200 300 -400 500 -600
0 2 0 0 7
1000 2000 3000 4000 5000 6000 7000
0 4 0 0 9
-5 10 -15 20 -25 30 -35 40 -45
1 2 0 0 5
11 -22 33 -44 55
1 3 0 0 4
-32768 32767 0 -1
2 4 0 0 5
0 1000 -1003 -2000 7
2 4 1 0 6
-100 -37 500 499 -32000 -31990
0 1 0 1 16
1 2 3 4 5 6 7 8 9 10 11 12 13 14 15 16

// ==== tests/tb_aud_playback.sv ====
`timescale 1ns/1ps

module tb_aud_playback import aud_pkg::*; ();

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        dac_lrck;
	logic        dac_data;

	int rec_mode[$];
	int rec_speed[$];
	int rec_pause[$];
	int rec_stop[$];
	int rec_len[$];
	int rec_base[$];
	int samp_q[$];
	int exp_q[$];
	int got_q[$];
	int errors = 0;
	int limit_cycles = 0;
	int mon_bits = 0;
	logic [15:0] mon_word;

	aud_playback_top uut (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_psel     (psel),
		.i_penable  (penable),
		.i_pwrite   (pwrite),
		.i_paddr    (paddr),
		.i_pwdata   (pwdata),
		.o_prdata   (prdata),
		.o_pready   (pready),
		.o_pslverr  (pslverr),
		.o_dac_lrck (dac_lrck),
		.o_dac_data (dac_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge clk);
		psel   = 1'b1;
		pwrite = 1'b1;
		paddr  = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(negedge clk);
		psel   = 1'b1;
		pwrite = 1'b0;
		paddr  = addr;
		@(negedge clk);
		penable = 1'b1;
		// access phase, sampled before the completing edge
		#10;
		data = prdata;
		err  = pslverr;
		check_value("pready", 1, pready);
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected !== actual) begin
			$display("FAILED at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	// frame list from the output rule for one record
	task automatic build_expected(input int r);
		int n, len, base, frames, k, i, j, d;
		n = rec_speed[r];
		len = rec_len[r];
		base = rec_base[r];
		exp_q.delete();
		frames = (rec_mode[r] == 0) ? (len + n - 1) / n : n * (len - 1) + 1;
		for (k = 0; k < frames; k++) begin
			i = k / n;
			j = k % n;
			if (rec_mode[r] == 0) begin
				exp_q.push_back(samp_q[base + k * n]);
			end else if (rec_mode[r] == 1 || i == len - 1) begin
				exp_q.push_back(samp_q[base + i]);
			end else begin
				d = (samp_q[base + i + 1] - samp_q[base + i]) / n;
				exp_q.push_back(samp_q[base + i] + j * d);
			end
		end
	endtask

	// collect the left word of every frame
	always @(negedge clk) begin
		if (dac_lrck) begin
			mon_word = {mon_word[14:0], dac_data};
			mon_bits++;
			if (mon_bits == FRAME_BITS) begin
				got_q.push_back($signed(mon_word));
				mon_bits = 0;
			end
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout, playback did not finish in the expected time");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		int fd, cnt, r, i, m, sp, pa, st, len, v, errs_before, ctrl, total, npass, nfail;
		string line;
		logic [31:0] rd;
		logic err;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rst_n = 1'b0;
		v = $urandom(5);
		npass = 0;
		nfail = 0;
		total = 0;
		fd = $fopen("tests/aud_playback_input.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				cnt = $fgets(line, fd);
				if (cnt > 1 && line[0] != "#") begin
					cnt = $sscanf(line, "%d %d %d %d %d", m, sp, pa, st, len);
					rec_mode.push_back(m);
					rec_speed.push_back(sp);
					rec_pause.push_back(pa);
					rec_stop.push_back(st);
					rec_len.push_back(len);
					rec_base.push_back(samp_q.size());
					for (i = 0; i < len; i++) begin
						cnt = $fscanf(fd, "%d", v);
						samp_q.push_back(v);
					end
				end
			end
			$fclose(fd);
		end
		for (r = 0; r < rec_len.size(); r++) begin
			build_expected(r);
			total = total + exp_q.size() * 2 * FRAME_BITS + rec_len[r] * 8 + 1000;
		end
		limit_cycles = total + 2000;

		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		apb_read(REG_STATUS, rd, err);
		check_value("status", 0, rd);
		check_value("pslverr", 0, err);
		check_value("dac_lrck", 0, dac_lrck);

		for (r = 0; r < rec_len.size(); r++) begin
			errs_before = errors;
			build_expected(r);
			if (got_q.size() != 0) begin
				$display("a frame was sent while the engine was idle before test %0d", r);
				errors++;
			end
			apb_write(REG_PTR, 0);
			for (i = 0; i < rec_len[r]; i++)
				apb_write(REG_DATA, samp_q[rec_base[r] + i] & 32'hFFFF);
			apb_read(REG_PTR, rd, err);
			check_value("ptr", rec_len[r], rd);
			apb_write(REG_LENGTH, rec_len[r]);
			ctrl = (rec_speed[r] << 8) | (rec_mode[r] << 4);
			got_q.delete();
			apb_write(REG_CTRL, ctrl | 1);
			if (rec_stop[r] != 0) begin
				while (got_q.size() < 3)
					@(negedge clk);
				apb_write(REG_CTRL, ctrl | 2);
				apb_read(REG_STATUS, rd, err);
				check_value("busy", 0, rd[0]);
				check_value("done", 0, rd[1]);
				// the frame in flight has to drain first
				repeat (80) @(negedge clk);
				check_value("dac_lrck", 0, dac_lrck);
				cnt = got_q.size();
				repeat (80) @(negedge clk);
				check_value("frames after stop", cnt, got_q.size());
				apb_read(8'h20, rd, err);
				check_value("pslverr", 1, err);
			end else begin
				if (rec_pause[r] != 0) begin
					repeat ($urandom_range(200, 40)) @(negedge clk);
					apb_write(REG_CTRL, ctrl | 4);
					// frames already begun still finish
					repeat (80) @(negedge clk);
					cnt = got_q.size();
					repeat ($urandom_range(300, 50)) @(negedge clk);
					check_value("frames while paused", cnt, got_q.size());
					check_value("dac_lrck", 0, dac_lrck);
					apb_write(REG_CTRL, ctrl);
				end
				rd = '0;
				while (rd[1] == 1'b0)
					apb_read(REG_STATUS, rd, err);
				check_value("busy", 0, rd[0]);
				check_value("sent_count", exp_q.size(), rd[29:16]);
				check_value("frame count", exp_q.size(), got_q.size());
			end
			for (i = 0; i < got_q.size() && i < exp_q.size(); i++)
				check_value($sformatf("frame %0d", i), exp_q[i], got_q[i]);
			if (errors == errs_before) begin
				npass++;
				$display("test %0d mode %0d speed %0d: %0d frames, ok",
					r, rec_mode[r], rec_speed[r], got_q.size());
			end else begin
				nfail++;
				$display("test %0d mode %0d speed %0d: mismatches found",
					r, rec_mode[r], rec_speed[r]);
			end
			got_q.delete();
		end

		repeat (64) @(negedge clk);
		if (got_q.size() != 0) begin
			$display("a frame was sent after the last test had ended");
			errors++;
		end
		$display("%0d tests passed, %0d tests failed", npass, nfail);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== rtl/aud_playback_top.sv ====
`timescale 1ns/1ps

module aud_playback_top import aud_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_psel,
	input  logic        i_penable,
	input  logic        i_pwrite,
	input  logic [7:0]  i_paddr,
	input  logic [31:0] i_pwdata,
	output logic [31:0] o_prdata,
	output logic        o_pready,
	output logic        o_pslverr,
	output logic        o_dac_lrck,
	output logic        o_dac_data
);

	// register block to memory
	logic       ram_we;
	saddr_t     ram_waddr;
	sample_t    ram_wdata;
	// engine side of the memory
	saddr_t     ram_raddr;
	sample_t    ram_rdata;
	// control to the engine
	logic       start;
	logic       stop;
	logic       pause;
	play_mode_t mode;
	speed_t     speed;
	saddr_t     length;
	// status back
	logic       busy;
	logic       done;
	count_t     sent_count;
	// sample handshake to the serializer
	logic       smp_valid;
	sample_t    smp_data;
	logic       smp_ready;
	logic       frame_sent;

	aud_apb_regs u_regs (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_psel       (i_psel),
		.i_penable    (i_penable),
		.i_pwrite     (i_pwrite),
		.i_paddr      (i_paddr),
		.i_pwdata     (i_pwdata),
		.o_prdata     (o_prdata),
		.o_pready     (o_pready),
		.o_pslverr    (o_pslverr),
		.o_ram_we     (ram_we),
		.o_ram_addr   (ram_waddr),
		.o_ram_wdata  (ram_wdata),
		.o_start      (start),
		.o_stop       (stop),
		.o_pause      (pause),
		.o_mode       (mode),
		.o_speed      (speed),
		.o_length     (length),
		.i_busy       (busy),
		.i_done       (done),
		.i_sent_count (sent_count)
	);

	aud_sample_ram u_ram (
		.i_clk   (i_clk),
		.i_we    (ram_we),
		.i_waddr (ram_waddr),
		.i_wdata (ram_wdata),
		.i_raddr (ram_raddr),
		.o_rdata (ram_rdata)
	);

	aud_speed_engine u_engine (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_start      (start),
		.i_stop       (stop),
		.i_pause      (pause),
		.i_mode       (mode),
		.i_speed      (speed),
		.i_length     (length),
		.o_raddr      (ram_raddr),
		.i_rdata      (ram_rdata),
		.o_valid      (smp_valid),
		.o_sample     (smp_data),
		.i_ready      (smp_ready),
		.i_sent       (frame_sent),
		.o_busy       (busy),
		.o_done       (done),
		.o_sent_count (sent_count)
	);

	aud_frame_tx u_tx (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_valid    (smp_valid),
		.i_sample   (smp_data),
		.o_ready    (smp_ready),
		.o_sent     (frame_sent),
		.o_dac_lrck (o_dac_lrck),
		.o_dac_data (o_dac_data)
	);

endmodule

// ==== rtl/aud_frame_tx.sv ====
`timescale 1ns/1ps

module aud_frame_tx import aud_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  logic    i_valid,
	input  sample_t i_sample,
	output logic    o_ready,
	output logic    o_sent,
	output logic    o_dac_lrck,
	output logic    o_dac_data
);

	logic                    active;
	logic [4:0]              bit_cnt;
	logic [2*FRAME_BITS-1:0] shift;
	logic                    frame_end;
	logic                    load;

	assign frame_end = active && (bit_cnt == 5'(2 * FRAME_BITS - 1));
	// new sample only at the frame boundary or when idle
	assign o_ready   = !active || frame_end;
	assign load      = i_valid && o_ready;
	assign o_sent    = frame_end;

	// left half while lrck high, then the right copy
	assign o_dac_lrck = active && (bit_cnt < 5'(FRAME_BITS));
	assign o_dac_data = active && shift[2*FRAME_BITS-1];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			active  <= 1'b0;
			bit_cnt <= '0;
		end else if (load) begin
			active  <= 1'b1;
			bit_cnt <= '0;
		end else if (frame_end) begin
			active  <= 1'b0;
		end else if (active) begin
			bit_cnt <= bit_cnt + 5'd1;
		end
	end

	// two copies, msb first
	always_ff @(posedge i_clk) begin
		if (load)
			shift <= {i_sample, i_sample};
		else
			shift <= shift << 1;
	end

endmodule

// ==== rtl/aud_speed_engine.sv ====
`timescale 1ns/1ps

module aud_speed_engine import aud_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_start,
	input  logic       i_stop,
	input  logic       i_pause,
	input  play_mode_t i_mode,
	input  speed_t     i_speed,
	input  saddr_t     i_length,
	output saddr_t     o_raddr,
	input  sample_t    i_rdata,
	output logic       o_valid,
	output sample_t    o_sample,
	input  logic       i_ready,
	input  logic       i_sent,
	output logic       o_busy,
	output logic       o_done,
	output count_t     o_sent_count
);

	eng_state_t state;
	play_mode_t mode_r;
	speed_t     speed_r;
	speed_t     rep_idx;
	saddr_t     src_idx;
	count_t     frames_left;
	count_t     sent_count;
	sample_t    samp_a;
	sample_t    sample_r;
	logic       busy;
	logic       done;
	logic [10:0] fast_frames;
	count_t     slow_frames;
	logic signed [16:0] diff;
	logic signed [16:0] step;
	logic signed [20:0] interp;
	logic       xfer;
	logic       last_rep;

	// frame totals, ceil(L/N) or N(L-1)+1
	always_comb begin
		fast_frames = (11'(i_length) + 11'(i_speed) - 11'd1) / 11'(i_speed);
		slow_frames = count_t'(i_speed) * count_t'(i_length - 10'd1) + 14'd1;
	end

	// i_rdata holds the right neighbour during COMPUTE
	always_comb begin
		diff   = {i_rdata[15], i_rdata} - {samp_a[15], samp_a};
		step   = diff / $signed({1'b0, speed_r});
		interp = samp_a + $signed({1'b0, rep_idx}) * step;
	end

	assign o_raddr  = (state == FETCH_A) ? src_idx : src_idx + saddr_t'(1);
	assign xfer     = (state == OFFER) && i_ready;
	assign last_rep = rep_idx == speed_r - 4'd1;

	assign o_valid      = state == OFFER;
	assign o_sample     = sample_r;
	assign o_busy       = busy;
	assign o_done       = done;
	assign o_sent_count = sent_count;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state       <= IDLE;
			mode_r      <= MODE_FAST;
			speed_r     <= SPEED_MIN;
			rep_idx     <= '0;
			src_idx     <= '0;
			frames_left <= '0;
			sent_count  <= '0;
			busy        <= 1'b0;
			done        <= 1'b0;
		end else begin
			done <= 1'b0;
			if (busy && i_sent)
				sent_count <= sent_count + 14'd1;
			if (i_stop) begin
				// abort, the serializer finishes its frame on its own
				state       <= IDLE;
				busy        <= 1'b0;
				frames_left <= '0;
			end else if (i_start) begin
				state       <= FETCH_A;
				busy        <= 1'b1;
				mode_r      <= i_mode;
				speed_r     <= i_speed;
				rep_idx     <= '0;
				src_idx     <= '0;
				sent_count  <= '0;
				frames_left <= (i_mode == MODE_FAST) ? count_t'(fast_frames) : slow_frames;
			end else begin
				case (state)
					IDLE: begin
						// wait for the last frame to leave the serializer
						if (busy && i_sent && frames_left == '0) begin
							busy <= 1'b0;
							done <= 1'b1;
						end
					end
					FETCH_A: state <= FETCH_B;
					FETCH_B: state <= COMPUTE;
					COMPUTE: state <= i_pause ? PAUSED : OFFER;
					PAUSED: begin
						if (!i_pause)
							state <= OFFER;
					end
					OFFER: begin
						if (xfer) begin
							frames_left <= frames_left - 14'd1;
							state <= (frames_left == 14'd1) ? IDLE : FETCH_A;
							if (mode_r == MODE_FAST) begin
								src_idx <= src_idx + saddr_t'(speed_r);
							end else if (last_rep) begin
								rep_idx <= '0;
								src_idx <= src_idx + saddr_t'(1);
							end else begin
								rep_idx <= rep_idx + 4'd1;
							end
						end
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	// sample datapath
	always_ff @(posedge i_clk) begin
		if (state == FETCH_B)
			samp_a <= i_rdata;
		if (state == COMPUTE)
			sample_r <= (mode_r == MODE_LINEAR) ? sample_t'(interp[15:0]) : samp_a;
	end

endmodule

// ==== rtl/aud_sample_ram.sv ====
`timescale 1ns/1ps

module aud_sample_ram import aud_pkg::*; (
	input  logic    i_clk,
	input  logic    i_we,
	input  saddr_t  i_waddr,
	input  sample_t i_wdata,
	input  saddr_t  i_raddr,
	output sample_t o_rdata
);

	sample_t mem [SAMPLE_DEPTH];

	// write port from the register block
	always_ff @(posedge i_clk) begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
	end

	// registered read, data one clock after the address
	always_ff @(posedge i_clk) begin
		o_rdata <= mem[i_raddr];
	end

endmodule

// ==== rtl/aud_apb_regs.sv ====
`timescale 1ns/1ps

module aud_apb_regs import aud_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_psel,
	input  logic        i_penable,
	input  logic        i_pwrite,
	input  logic [7:0]  i_paddr,
	input  logic [31:0] i_pwdata,
	output logic [31:0] o_prdata,
	output logic        o_pready,
	output logic        o_pslverr,
	output logic        o_ram_we,
	output saddr_t      o_ram_addr,
	output sample_t     o_ram_wdata,
	output logic        o_start,
	output logic        o_stop,
	output logic        o_pause,
	output play_mode_t  o_mode,
	output speed_t      o_speed,
	output saddr_t      o_length,
	input  logic        i_busy,
	input  logic        i_done,
	input  count_t      i_sent_count
);

	logic   wr_en;
	logic   addr_ok;
	logic   done_r;
	saddr_t ptr;
	speed_t wr_speed;

	assign wr_en    = i_psel && i_penable && i_pwrite;
	assign o_pready = 1'b1;
	assign o_pslverr = i_psel && i_penable && !addr_ok;

	// clamp the written speed into 1..8
	always_comb begin
		wr_speed = speed_t'(i_pwdata[11:8]);
		if (wr_speed < SPEED_MIN)
			wr_speed = SPEED_MIN;
		else if (wr_speed > SPEED_MAX)
			wr_speed = SPEED_MAX;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_start  <= 1'b0;
			o_stop   <= 1'b0;
			o_pause  <= 1'b0;
			o_mode   <= MODE_FAST;
			o_speed  <= SPEED_MIN;
			o_length <= '0;
			o_ram_we <= 1'b0;
			ptr      <= '0;
			done_r   <= 1'b0;
		end else begin
			// start and stop are single cycle pulses
			o_start  <= 1'b0;
			o_stop   <= 1'b0;
			o_ram_we <= 1'b0;
			if (i_done)
				done_r <= 1'b1;
			if (wr_en) begin
				case (i_paddr)
					REG_CTRL: begin
						o_start <= i_pwdata[0];
						o_stop  <= i_pwdata[1];
						o_pause <= i_pwdata[2];
						o_mode  <= play_mode_t'(i_pwdata[5:4]);
						o_speed <= wr_speed;
						if (i_pwdata[0])
							done_r <= 1'b0;
					end
					REG_LENGTH: o_length <= i_pwdata[9:0];
					REG_PTR:    ptr <= i_pwdata[9:0];
					REG_DATA: begin
						o_ram_we <= 1'b1;
						ptr      <= ptr + saddr_t'(1);
					end
					default: ;
				endcase
			end
		end
	end

	// memory write lands one cycle after the access
	always_ff @(posedge i_clk) begin
		if (wr_en && i_paddr == REG_DATA) begin
			o_ram_addr  <= ptr;
			o_ram_wdata <= i_pwdata[15:0];
		end
	end

	always_comb begin
		o_prdata = '0;
		addr_ok  = 1'b1;
		case (i_paddr)
			REG_CTRL:   o_prdata = {20'd0, o_speed, 2'b00, o_mode, 1'b0, o_pause, 2'b00};
			REG_LENGTH: o_prdata = {22'd0, o_length};
			REG_PTR:    o_prdata = {22'd0, ptr};
			// data is write only
			REG_DATA:   o_prdata = '0;
			REG_STATUS: o_prdata = {2'b00, i_sent_count, 14'd0, done_r, i_busy};
			default:    addr_ok = 1'b0;
		endcase
	end

endmodule

// ==== rtl/aud_pkg.sv ====
package aud_pkg;

	// audio sample and memory addressing
	typedef logic signed [15:0] sample_t;
	typedef logic [9:0] saddr_t;
	localparam int SAMPLE_DEPTH = 1024;

	// speed factor, 1 to 8
	typedef logic [3:0] speed_t;
	localparam speed_t SPEED_MIN = 4'd1;
	localparam speed_t SPEED_MAX = 4'd8;

	typedef enum logic [1:0] {
		MODE_FAST   = 2'd0,
		MODE_HOLD   = 2'd1,
		MODE_LINEAR = 2'd2
	} play_mode_t;

	// sent frames, up to 8 * 1023 + 1
	typedef logic [13:0] count_t;

	// apb register offsets
	localparam logic [7:0] REG_CTRL   = 8'h00;
	localparam logic [7:0] REG_LENGTH = 8'h04;
	localparam logic [7:0] REG_PTR    = 8'h08;
	localparam logic [7:0] REG_DATA   = 8'h0C;
	localparam logic [7:0] REG_STATUS = 8'h10;

	// clocks per half frame
	localparam int FRAME_BITS = 16;

	typedef enum logic [2:0] {IDLE, FETCH_A, FETCH_B, COMPUTE, OFFER, PAUSED} eng_state_t;

endpackage
